/* bench/tbSnake.sv */
`include "snake_cfg.svh"

module tbSnake import gamePkg::*; import videoPkg::*; ();

    localparam int ClkPeriod     = 8;
    localparam int NumRandom     = 40;
    localparam int MaxSteps      = 80;
    localparam int StepCycles    = 50;
    localparam int TimeoutCycles = (NumRandom + 2 * MaxSteps + 10) * StepCycles + 200;

    logic  clkVGA = 1'b0;
    logic  reset, moveTick, keyUp, keyDown, keyLeft, keyRight, videoValid;
    scanT  hCount, vCount;
    colorT vgaRed, vgaGreen, vgaBlue;
    logic  consume;
    lenT   length;

    // Reference model state
    int  mCntX, mCntY, mHeadX, mHeadY, mAppleX, mAppleY, mLen;
    int  mSegX [1:`MAX_LEN-1];
    int  mSegY [1:`MAX_LEN-1];
    dirT mDir;
    bit  mOver, mAte;
    int  errors = 0;
    int  checks = 0;
    int  pendH [$];
    int  pendV [$];
    bit  pendOn [$];

    snakeTop uut (
        .clkVGA(clkVGA), .reset(reset), .moveTick(moveTick),
        .keyUp(keyUp), .keyDown(keyDown), .keyLeft(keyLeft), .keyRight(keyRight),
        .hCount(hCount), .vCount(vCount), .videoValid(videoValid),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue),
        .consume(consume), .length(length)
    );

    always #(ClkPeriod / 2) clkVGA = ~clkVGA;

    // Locator counters from their wrap rules
    always @(posedge clkVGA) begin
        if (reset) begin
            mCntX <= `RAND_X_MIN;
            mCntY <= `RAND_Y_MIN;
        end else begin
            mCntX <= (mCntX >= `RAND_X_MAX) ? `RAND_X_MIN : mCntX + `RAND_X_STEP;
            mCntY <= (mCntY >= `RAND_Y_MAX) ? `RAND_Y_MIN : mCntY + 1;
        end
    end

    initial begin
        #(TimeoutCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, run stopped", TimeoutCycles);
        $display("tests failed");
        $finish;
    end

    function automatic dirT reverseOf(input dirT d);
        case (d)
            dirUp:   return dirDown;
            dirDown: return dirUp;
            dirLeft: return dirRight;
            default: return dirLeft;
        endcase
    endfunction

    function automatic dirT towardApple();
        if (mHeadY > mAppleY) return dirUp;
        if (mHeadY < mAppleY) return dirDown;
        if (mHeadX > mAppleX) return dirLeft;
        return dirRight;
    endfunction

    function automatic bit inSquare(input int h, input int v, input int x, input int y);
        return (h >= x) && (h < x + `CELL) && (v >= y) && (v < y + `CELL);
    endfunction

    // Expected {red, green, blue} of one pixel
    function automatic logic [11:0] expectColor(input int h, input int v, input bit on);
        bit border;
        bit snake;
        logic [3:0] r, g, b;
        border = (h < `BORDER_LO) || (h > `BORDER_RIGHT) ||
                 (v < `BORDER_LO) || (v > `BORDER_BOTTOM);
        snake = inSquare(h, v, mHeadX, mHeadY);
        for (int i = 1; i < `MAX_LEN; i++) begin
            snake |= inSquare(h, v, mSegX[i], mSegY[i]);
        end
        r = ((inSquare(h, v, mAppleX, mAppleY) && !border) || mOver) ? 4'hF : 4'h0;
        g = (snake && !mOver) ? 4'hF : 4'h0;
        b = (border && !mOver) ? 4'hF : 4'h0;
        return on ? {r, g, b} : 12'h000;
    endfunction

    task automatic queuePixel(input int h, input int v, input bit on);
        pendH.push_back(h);
        pendV.push_back(v);
        pendOn.push_back(on);
    endtask

    task automatic queueSnake();
        queuePixel(mHeadX + 5, mHeadY + 5, 1'b1);
        for (int i = 1; i < mLen; i++) begin
            queuePixel(mSegX[i] + 5, mSegY[i] + 5, 1'b1);
        end
    endtask

    // One cell behind the head, against the motion
    task automatic queueBehind();
        case (mDir)
            dirUp:   queuePixel(mHeadX + 5, mHeadY + 15, 1'b1);
            dirDown: queuePixel(mHeadX + 5, mHeadY - 5, 1'b1);
            dirLeft: queuePixel(mHeadX + 15, mHeadY + 5, 1'b1);
            default: queuePixel(mHeadX - 5, mHeadY + 5, 1'b1);
        endcase
    endtask

    // One pixel per cycle, colors two cycles later
    task automatic runProbe(input string name);
        int n;
        logic [11:0] want;
        logic [11:0] got;
        n = pendH.size();
        for (int k = 0; k < n + 2; k++) begin
            @(posedge clkVGA);
            if (k < n) begin
                hCount     <= scanT'(pendH[k]);
                vCount     <= scanT'(pendV[k]);
                videoValid <= pendOn[k];
            end else begin
                videoValid <= 1'b0;
            end
            @(negedge clkVGA);
            if (k >= 2) begin
                want = expectColor(pendH[k-2], pendV[k-2], pendOn[k-2]);
                got  = {vgaRed, vgaGreen, vgaBlue};
                checks++;
                if (got !== want) begin
                    errors++;
                    $display("FAIL %s pixel (%0d,%0d) expected %h actual %h",
                             name, pendH[k-2], pendV[k-2], want, got);
                end
            end
        end
        pendH.delete();
        pendV.delete();
        pendOn.delete();
    endtask

    ////////////////////////////////
    // Game step on the model
    ////////////////////////////////

    task automatic advanceModel();
        mAte = (mHeadX == mAppleX) && (mHeadY == mAppleY);
        for (int i = `MAX_LEN - 1; i >= 2; i--) begin
            if (mLen > i) begin
                mSegX[i] = mSegX[i-1];
                mSegY[i] = mSegY[i-1];
            end
        end
        if (mLen > 1) begin
            mSegX[1] = mHeadX;
            mSegY[1] = mHeadY;
        end
        case (mDir)
            dirUp:   mHeadY = (mHeadY - `CELL < `HEAD_MIN) ? `HEAD_MIN : mHeadY - `CELL;
            dirDown: mHeadY = (mHeadY + `CELL > `HEAD_MAX_Y) ? `HEAD_MAX_Y : mHeadY + `CELL;
            dirLeft: mHeadX = (mHeadX - `CELL < `HEAD_MIN) ? `HEAD_MIN : mHeadX - `CELL;
            default: mHeadX = (mHeadX + `CELL > `HEAD_MAX_X) ? `HEAD_MAX_X : mHeadX + `CELL;
        endcase
        if (mAte) begin
            mAppleX = mCntX * `CELL;
            mAppleY = mCntY * `CELL;
            if (mLen < `MAX_LEN) mLen++;
        end
        if ((mHeadX < `BORDER_LO) || (mHeadX + `CELL > `BORDER_RIGHT) ||
            (mHeadY < `BORDER_LO) || (mHeadY + `CELL > `BORDER_BOTTOM)) begin
            mOver = 1'b1;
        end
        for (int i = 1; i < `MAX_LEN; i++) begin
            if ((mHeadX == mSegX[i]) && (mHeadY == mSegY[i])) mOver = 1'b1;
        end
    endtask

    // Key for one cycle, then a tick
    task automatic doMove(input dirT key, input string name);
        @(posedge clkVGA);
        keyUp    <= (key == dirUp);
        keyDown  <= (key == dirDown);
        keyLeft  <= (key == dirLeft);
        keyRight <= (key == dirRight);
        @(posedge clkVGA);
        {keyUp, keyDown, keyLeft, keyRight} <= 4'b0000;
        moveTick <= 1'b1;
        if ((key != reverseOf(mDir)) || (mLen == 1)) mDir = key;
        @(posedge clkVGA);
        moveTick <= 1'b0;
        advanceModel();
        @(negedge clkVGA);
        checks += 2;
        if (consume !== mAte) begin
            errors++;
            $display("FAIL %s consume expected %0d actual %0d", name, mAte, consume);
        end
        if (length !== lenT'(mLen)) begin
            errors++;
            $display("FAIL %s length expected %0d actual %0d", name, mLen, length);
        end
        @(posedge clkVGA);
        @(negedge clkVGA);
        checks++;
        if (consume !== 1'b0) begin
            errors++;
            $display("%s: consume stayed high for a second cycle", name);
        end
    endtask

    task automatic applyReset();
        @(posedge clkVGA);
        reset <= 1'b1;
        repeat (16) @(posedge clkVGA);
        reset <= 1'b0;
        mHeadX  = `HEAD_START_X;
        mHeadY  = `HEAD_START_Y;
        mAppleX = `APPLE_START_X;
        mAppleY = `APPLE_START_Y;
        for (int i = 1; i < `MAX_LEN; i++) begin
            mSegX[i] = `PARKED;
            mSegY[i] = `PARKED;
        end
        mDir  = dirUp;
        mLen  = 1;
        mOver = 1'b0;
        mAte  = 1'b0;
    endtask

    task automatic checkReset(input string name);
        queuePixel(305, 305, 1'b1);
        queuePixel(205, 105, 1'b1);
        queuePixel(5, 5, 1'b1);
        queuePixel(100, 200, 1'b1);
        queuePixel(305, 305, 1'b0);
        runProbe(name);
        checks++;
        if (length !== lenT'(1)) begin
            errors++;
            $display("FAIL %s length expected 1 actual %0d", name, length);
        end
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////

    initial begin
        int steps;
        void'($urandom(71));
        reset      <= 1'b1;
        moveTick   <= 1'b0;
        {keyUp, keyDown, keyLeft, keyRight} <= 4'b0000;
        hCount     <= '0;
        vCount     <= '0;
        videoValid <= 1'b0;
        applyReset();
        checkReset("reset state");

        for (int n = 0; n < NumRandom; n++) begin
            doMove(dirT'(2'($urandom % 4)), "random move");
            queueSnake();
            queueBehind();
            runProbe("random move");
        end

        // Fresh start, then head straight for the apple
        applyReset();
        steps = 0;
        while ((mLen == 1) && (steps < MaxSteps)) begin
            doMove(towardApple(), "steer to apple");
            steps++;
        end
        if (mLen == 1) begin
            errors++;
            $display("Steered run never reached the apple");
        end
        queuePixel(mAppleX + 5, mAppleY + 5, 1'b1);
        queueSnake();
        runProbe("apple relocated");

        for (int n = 0; n < 4; n++) begin
            doMove(mDir, "grown snake");
            queueSnake();
            runProbe("grown snake");
        end
        doMove(reverseOf(mDir), "reversal refused");
        queueSnake();
        queueBehind();
        runProbe("reversal refused");

        steps = 0;
        while (!mOver && (steps < MaxSteps)) begin
            doMove(dirUp, "drive to border");
            steps++;
        end
        if (!mOver) begin
            errors++;
            $display("Head never reached the border");
        end
        for (int n = 0; n < 2; n++) begin
            queuePixel(5, 5, 1'b1);
            queuePixel(305, 305, 1'b1);
            queueSnake();
            runProbe("game over");
            doMove(dirUp, "game over held");
        end

        applyReset();
        checkReset("reset after game over");

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verilog
verilog/gamePkg.sv
verilog/videoPkg.sv
verilog/appleLocator.sv
verilog/snakeEngine.sv
verilog/bodyStore.sv
verilog/pixelRenderer.sv
verilog/snakeTop.sv
bench/tbSnake.sv

/* verilog/appleLocator.sv */
`include "snake_cfg.svh"

module appleLocator import gamePkg::*; (
    input  logic  clkVGA,
    input  logic  reset,
    output coordT randX,
    output coordT randY
);

    localparam coordT   CellW = coordT'(`CELL);
    localparam logic [6:0] XMin  = 7'(`RAND_X_MIN);
    localparam logic [6:0] XMax  = 7'(`RAND_X_MAX);
    localparam logic [6:0] XStep = 7'(`RAND_X_STEP);
    localparam logic [5:0] YMin  = 6'(`RAND_Y_MIN);
    localparam logic [5:0] YMax  = 6'(`RAND_Y_MAX);
    localparam coordT FieldLo    = coordT'(`BORDER_LO);
    localparam coordT FieldRight = coordT'(`BORDER_RIGHT);

    logic [6:0] cntX;
    logic [5:0] cntY;

    // Different periods, so the pair wanders over the field
    always_ff @(posedge clkVGA) begin
        if (reset) begin
            cntX <= XMin;
            cntY <= YMin;
        end else begin
            cntX <= (cntX >= XMax) ? XMin : cntX + XStep;
            cntY <= (cntY >= YMax) ? YMin : cntY + 6'd1;
        end
    end

    assign randX = coordT'(cntX) * CellW;
    assign randY = coordT'(cntY) * CellW;

    // Whole apple square between the left and right border
    xInField: assert property (@(posedge clkVGA) disable iff (reset)
        (randX >= FieldLo) && (randX + CellW <= FieldRight))
        else $error("apple x out of field: %0d", randX);

endmodule

/* verilog/bodyStore.sv */
`include "snake_cfg.svh"

module bodyStore import gamePkg::*; (
    input  logic  clkVGA,
    input  logic  reset,
    input  logic  moveTick,
    input  coordT headX,
    input  coordT headY,
    input  lenT   length,
    output coordT segX [1:`MAX_LEN-1],
    output coordT segY [1:`MAX_LEN-1],
    output logic  bodyHit
);

    localparam coordT Parked = coordT'(`PARKED);

    // Segment i follows segment i-1, segment 0 being the head
    always_ff @(posedge clkVGA) begin
        if (reset) begin
            for (int i = 1; i < `MAX_LEN; i++) begin
                segX[i] <= Parked;
                segY[i] <= Parked;
            end
        end else if (moveTick) begin
            if (length > lenT'(1)) begin
                segX[1] <= headX;
                segY[1] <= headY;
            end
            for (int i = 2; i < `MAX_LEN; i++) begin
                if (length > lenT'(i)) begin
                    segX[i] <= segX[i-1];
                    segY[i] <= segY[i-1];
                end
            end
        end
    end

    // Parked segments lie beyond the head clamp and never match
    always_comb begin
        bodyHit = 1'b0;
        for (int i = 1; i < `MAX_LEN; i++) begin
            bodyHit |= (headX == segX[i]) && (headY == segY[i]);
        end
    end

    ////////////////////////////////
    // Inactive segments stay put
    ////////////////////////////////

    for (genvar g = 1; g < `MAX_LEN; g++) begin : gIdle
        idleStable: assert property (@(posedge clkVGA) disable iff (reset)
            (moveTick && length <= lenT'(g)) |=> ($stable(segX[g]) && $stable(segY[g])))
            else $error("segment %0d moved while inactive", g);
    end

endmodule

/* verilog/gamePkg.sv */
package gamePkg;

    // Screen coordinate of a grid square corner
    typedef logic [9:0] coordT;

    // Direction of motion
    typedef enum logic [1:0] {
        dirUp,
        dirDown,
        dirLeft,
        dirRight
    } dirT;

    // Snake length, head included
    typedef logic [5:0] lenT;

endpackage

/* verilog/pixelRenderer.sv */
`include "snake_cfg.svh"

module pixelRenderer import gamePkg::*; import videoPkg::*; (
    input  logic  clkVGA,
    input  logic  reset,
    input  scanT  hCount,
    input  scanT  vCount,
    input  logic  videoValid,
    input  coordT headX,
    input  coordT headY,
    input  coordT appleX,
    input  coordT appleY,
    input  coordT segX [1:`MAX_LEN-1],
    input  coordT segY [1:`MAX_LEN-1],
    input  logic  gameOver,
    output colorT vgaRed,
    output colorT vgaGreen,
    output colorT vgaBlue
);

    localparam coordT CellW        = coordT'(`CELL);
    localparam scanT  BorderLo     = scanT'(`BORDER_LO);
    localparam scanT  BorderRight  = scanT'(`BORDER_RIGHT);
    localparam scanT  BorderBottom = scanT'(`BORDER_BOTTOM);
    localparam colorT Full         = colorT'(15);

    logic bodyAny;
    logic borderFlag;
    logic appleFlag;
    logic headFlag;
    logic bodyFlag;
    logic validQ;

    // Position inside a square starting at corner
    function automatic logic inCell(input scanT pos, input coordT corner);
        return (pos >= corner) && (pos < corner + CellW);
    endfunction

    always_comb begin
        bodyAny = 1'b0;
        for (int i = 1; i < `MAX_LEN; i++) begin
            bodyAny |= inCell(hCount, segX[i]) && inCell(vCount, segY[i]);
        end
    end

    ////////////////////////////////
    // Stage one: hit flags
    ////////////////////////////////

    always_ff @(posedge clkVGA) begin
        borderFlag <= (hCount < BorderLo) || (hCount > BorderRight) ||
                      (vCount < BorderLo) || (vCount > BorderBottom);
        appleFlag  <= inCell(hCount, appleX) && inCell(vCount, appleY);
        headFlag   <= inCell(hCount, headX) && inCell(vCount, headY);
        bodyFlag   <= bodyAny;
    end

    always_ff @(posedge clkVGA) begin
        if (reset) begin
            validQ <= 1'b0;
        end else begin
            validQ <= videoValid;
        end
    end

    ////////////////////////////////
    // Stage two: colors
    ////////////////////////////////

    always_ff @(posedge clkVGA) begin
        if (reset || !validQ) begin
            vgaRed   <= '0;
            vgaGreen <= '0;
            vgaBlue  <= '0;
        end else begin
            vgaBlue  <= (borderFlag && !gameOver) ? Full : '0;
            // Whole field turns red on game over
            vgaRed   <= ((appleFlag && !borderFlag) || gameOver) ? Full : '0;
            vgaGreen <= ((headFlag || bodyFlag) && !gameOver) ? Full : '0;
        end
    end

endmodule

/* verilog/snakeEngine.sv */
`include "snake_cfg.svh"

module snakeEngine import gamePkg::*; (
    input  logic  clkVGA,
    input  logic  reset,
    input  logic  moveTick,
    input  logic  keyUp,
    input  logic  keyDown,
    input  logic  keyLeft,
    input  logic  keyRight,
    input  logic  bodyHit,
    input  coordT randX,
    input  coordT randY,
    output coordT headX,
    output coordT headY,
    output coordT appleX,
    output coordT appleY,
    output lenT   length,
    output logic  consume,
    output logic  gameOver
);

    localparam coordT CellW        = coordT'(`CELL);
    localparam coordT HeadMin      = coordT'(`HEAD_MIN);
    localparam coordT HeadMaxX     = coordT'(`HEAD_MAX_X);
    localparam coordT HeadMaxY     = coordT'(`HEAD_MAX_Y);
    localparam coordT BorderLo     = coordT'(`BORDER_LO);
    localparam coordT BorderRight  = coordT'(`BORDER_RIGHT);
    localparam coordT BorderBottom = coordT'(`BORDER_BOTTOM);
    localparam lenT   MaxLen       = lenT'(`MAX_LEN);

    dirT  dir;
    dirT  keyDir;
    logic keyValid;
    logic appleHit;
    logic borderOut;

    function automatic dirT opposite(input dirT d);
        dirT o;
        case (d)
            dirUp:   o = dirDown;
            dirDown: o = dirUp;
            dirLeft: o = dirRight;
            default: o = dirLeft;
        endcase
        return o;
    endfunction

    ////////////////////////////////
    // Steering
    ////////////////////////////////

    // Only a single pressed key counts
    always_comb begin
        keyValid = 1'b1;
        keyDir   = dirUp;
        case ({keyUp, keyDown, keyLeft, keyRight})
            4'b1000: keyDir = dirUp;
            4'b0100: keyDir = dirDown;
            4'b0010: keyDir = dirLeft;
            4'b0001: keyDir = dirRight;
            default: keyValid = 1'b0;
        endcase
    end

    // No reversal once there is a body behind the head
    always_ff @(posedge clkVGA) begin
        if (reset) begin
            dir <= dirUp;
        end else if (keyValid && (keyDir != opposite(dir) || length == lenT'(1))) begin
            dir <= keyDir;
        end
    end

    ////////////////////////////////
    // Head motion
    ////////////////////////////////

    always_ff @(posedge clkVGA) begin
        if (reset) begin
            headX <= coordT'(`HEAD_START_X);
            headY <= coordT'(`HEAD_START_Y);
        end else if (moveTick) begin
            case (dir)
                dirUp:   headY <= (headY <= HeadMin) ? HeadMin : headY - CellW;
                dirDown: headY <= (headY >= HeadMaxY) ? HeadMaxY : headY + CellW;
                dirLeft: headX <= (headX <= HeadMin) ? HeadMin : headX - CellW;
                default: headX <= (headX >= HeadMaxX) ? HeadMaxX : headX + CellW;
            endcase
        end
    end

    // Both on the grid, so equal corners mean overlap
    assign appleHit = (headX == appleX) && (headY == appleY);

    always_ff @(posedge clkVGA) begin
        if (reset) begin
            appleX  <= coordT'(`APPLE_START_X);
            appleY  <= coordT'(`APPLE_START_Y);
            length  <= lenT'(1);
            consume <= 1'b0;
        end else begin
            consume <= moveTick && appleHit;
            if (moveTick && appleHit) begin
                appleX <= randX;
                appleY <= randY;
                if (length < MaxLen) begin
                    length <= length + lenT'(1);
                end
            end
        end
    end

    ////////////////////////////////
    // Game over
    ////////////////////////////////

    assign borderOut = (headX < BorderLo) || (headX + CellW > BorderRight) ||
                       (headY < BorderLo) || (headY + CellW > BorderBottom);

    // Sticky until reset
    always_ff @(posedge clkVGA) begin
        if (reset) begin
            gameOver <= 1'b0;
        end else if (borderOut || bodyHit) begin
            gameOver <= 1'b1;
        end
    end

    consumeSingle: assert property (@(posedge clkVGA) disable iff (reset)
        consume |=> !consume)
        else $error("consume held high for two cycles");

    lengthBound: assert property (@(posedge clkVGA) disable iff (reset)
        length <= MaxLen)
        else $error("length %0d above limit", length);

endmodule

/* verilog/snakeTop.sv */
`include "snake_cfg.svh"

module snakeTop import gamePkg::*; import videoPkg::*; (
    input  logic  clkVGA,
    input  logic  reset,
    input  logic  moveTick,
    input  logic  keyUp,
    input  logic  keyDown,
    input  logic  keyLeft,
    input  logic  keyRight,
    input  scanT  hCount,
    input  scanT  vCount,
    input  logic  videoValid,
    output colorT vgaRed,
    output colorT vgaGreen,
    output colorT vgaBlue,
    output logic  consume,
    output lenT   length
);

    coordT randX;
    coordT randY;
    coordT headX;
    coordT headY;
    coordT appleX;
    coordT appleY;
    coordT segX [1:`MAX_LEN-1];
    coordT segY [1:`MAX_LEN-1];
    logic  bodyHit;
    logic  gameOver;

    appleLocator locator (
        .clkVGA(clkVGA), .reset(reset), .randX(randX), .randY(randY)
    );

    snakeEngine engine (
        .clkVGA(clkVGA), .reset(reset), .moveTick(moveTick),
        .keyUp(keyUp), .keyDown(keyDown), .keyLeft(keyLeft), .keyRight(keyRight),
        .bodyHit(bodyHit), .randX(randX), .randY(randY),
        .headX(headX), .headY(headY), .appleX(appleX), .appleY(appleY),
        .length(length), .consume(consume), .gameOver(gameOver)
    );

    bodyStore body (
        .clkVGA(clkVGA), .reset(reset), .moveTick(moveTick),
        .headX(headX), .headY(headY), .length(length),
        .segX(segX), .segY(segY), .bodyHit(bodyHit)
    );

    pixelRenderer renderer (
        .clkVGA(clkVGA), .reset(reset),
        .hCount(hCount), .vCount(vCount), .videoValid(videoValid),
        .headX(headX), .headY(headY), .appleX(appleX), .appleY(appleY),
        .segX(segX), .segY(segY), .gameOver(gameOver),
        .vgaRed(vgaRed), .vgaGreen(vgaGreen), .vgaBlue(vgaBlue)
    );

endmodule

/* verilog/snake_cfg.svh */
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

// Grid step and square size
`define CELL            10

// Playing field border
`define BORDER_LO       20
`define BORDER_RIGHT    620
`define BORDER_BOTTOM   460

// Head clamp limits
`define HEAD_MIN        10
`define HEAD_MAX_X      620
`define HEAD_MAX_Y      460

// Start positions
`define HEAD_START_X    300
`define HEAD_START_Y    300
`define APPLE_START_X   200
`define APPLE_START_Y   100

// Unused segments sit off screen
`define PARKED          700
`define MAX_LEN         32

// Apple locator counter range, in cells
`define RAND_X_MIN      2
`define RAND_X_MAX      60
`define RAND_X_STEP     2
`define RAND_Y_MIN      2
`define RAND_Y_MAX      42

`endif

/* verilog/videoPkg.sv */
package videoPkg;

    // One 4-bit color channel level
    typedef logic [3:0] colorT;

    // Horizontal or vertical scan position
    typedef logic [9:0] scanT;

endpackage
